// ==== flist.f ====
logic/fetch_pkg.sv
logic/fetch_result_if.sv
logic/if_stage.sv
logic/redirect_unit.sv
logic/fetch_packer.sv
logic/fetch_top.sv
verification/fetch_mem_model.sv
verification/fetch_tb.sv

// ==== logic/fetch_packer.sv ====
/* fetch packer
   pre-decodes the fetched word into an opcode class and drives the pipeline output */
`timescale 1ns/1ps

module fetch_packer (
  fetch_result_if.consumer             res,
  output logic                         fetch_valid,
  output logic [fetch_pkg::xlen-1:0]   fetch_pc,
  output logic [fetch_pkg::inst_w-1:0] fetch_inst,
  output fetch_pkg::op_class_e         fetch_op,
  output logic                         fetch_redirected
);

  logic [6:0]           opcode;
  fetch_pkg::op_class_e op_dec;

  assign opcode = res.inst[6:0];

  always_comb begin
    op_dec = fetch_pkg::op_illegal;
    if (opcode[1:0] == 2'b11) begin  // otherwise compressed, not supported
      case (opcode)
        fetch_pkg::opc_op,
        fetch_pkg::opc_op_imm,
        fetch_pkg::opc_op_32,
        fetch_pkg::opc_op_imm_32,
        fetch_pkg::opc_lui,
        fetch_pkg::opc_auipc:
          op_dec = fetch_pkg::op_alu;
        fetch_pkg::opc_load:
          op_dec = fetch_pkg::op_load;
        fetch_pkg::opc_store:
          op_dec = fetch_pkg::op_store;
        fetch_pkg::opc_branch:
          op_dec = fetch_pkg::op_branch;
        fetch_pkg::opc_jal:
          op_dec = fetch_pkg::op_jal;
        fetch_pkg::opc_jalr:
          op_dec = fetch_pkg::op_jalr;
        fetch_pkg::opc_system,
        fetch_pkg::opc_misc_mem:
          op_dec = fetch_pkg::op_system;  // fence handled with system ops
        default:
          op_dec = fetch_pkg::op_illegal;
      endcase
    end
  end

  // output only carries data while an item is presented
  assign fetch_valid      = res.done;
  assign fetch_redirected = res.done & res.redirected;

  always_comb begin
    if (res.done) begin
      fetch_pc   = res.pc;
      fetch_inst = res.inst;
      fetch_op   = op_dec;
    end else begin
      fetch_pc   = '0;
      fetch_inst = '0;
      fetch_op   = fetch_pkg::op_illegal;
    end
  end

endmodule

// ==== logic/fetch_pkg.sv ====
/* fetch package
   widths, reset pc, opcode constants and the enums shared by the fetch blocks */
package fetch_pkg;

  localparam int xlen   = 64;  // register and address width
  localparam int inst_w = 32;  // instruction width

  localparam logic [xlen-1:0] pc_start = 64'h0000_0000_8000_0000;
  localparam logic [xlen-1:0] pc_step  = 64'd4;  // no compressed instructions

  // major opcodes, inst[6:0]
  localparam logic [6:0] opc_load      = 7'b000_0011;
  localparam logic [6:0] opc_misc_mem  = 7'b000_1111;
  localparam logic [6:0] opc_op_imm    = 7'b001_0011;
  localparam logic [6:0] opc_auipc     = 7'b001_0111;
  localparam logic [6:0] opc_op_imm_32 = 7'b001_1011;
  localparam logic [6:0] opc_store     = 7'b010_0011;
  localparam logic [6:0] opc_op        = 7'b011_0011;
  localparam logic [6:0] opc_lui       = 7'b011_0111;
  localparam logic [6:0] opc_op_32     = 7'b011_1011;
  localparam logic [6:0] opc_branch    = 7'b110_0011;
  localparam logic [6:0] opc_jalr      = 7'b110_0111;
  localparam logic [6:0] opc_jal       = 7'b110_1111;
  localparam logic [6:0] opc_system    = 7'b111_0011;

  // coarse class handed to the pipeline with each instruction
  typedef enum logic [2:0] {
    op_alu     = 3'd0,
    op_load    = 3'd1,
    op_store   = 3'd2,
    op_branch  = 3'd3,
    op_jal     = 3'd4,
    op_jalr    = 3'd5,
    op_system  = 3'd6,
    op_illegal = 3'd7
  } op_class_e;

  // fetch FSM
  typedef enum logic [1:0] {
    idle = 2'd0,  // waiting for the first refresh
    addr = 2'd1,  // request on the bus
    retn = 2'd2   // item held for the pipeline
  } fetch_state_e;

endpackage

// ==== logic/fetch_result_if.sv ====
/* fetch result channel
   one fetched item from the bus FSM to the packer */
`timescale 1ns/1ps

interface fetch_result_if;

  logic                         done;        // item presented
  logic [fetch_pkg::xlen-1:0]   pc;          // address of the item
  logic [fetch_pkg::inst_w-1:0] inst;        // raw instruction word
  logic                         redirected;  // successor came from a redirect

  // bus FSM side
  modport producer (
    output done,
    output pc,
    output inst,
    output redirected
  );

  // packer side, read only
  modport consumer (
    input done,
    input pc,
    input inst,
    input redirected
  );

endinterface

// ==== logic/fetch_top.sv ====
/* instruction fetch top
   bus FSM, redirect holding and pre-decode behind plain ports */
`timescale 1ns/1ps

module fetch_top (
  input  logic                         clk,
  input  logic                         rst,
  input  logic                         refresh,
  input  logic                         bj_ena,
  input  logic [fetch_pkg::xlen-1:0]   bj_pc,
  input  logic                         excp_ena,
  input  logic [fetch_pkg::xlen-1:0]   excp_pc,
  output logic                         bus_valid,
  input  logic                         bus_ready,
  output logic [fetch_pkg::xlen-1:0]   bus_addr,
  input  logic [fetch_pkg::xlen-1:0]   bus_rdata,
  output logic                         fetch_valid,
  output logic [fetch_pkg::xlen-1:0]   fetch_pc,
  output logic [fetch_pkg::inst_w-1:0] fetch_inst,
  output fetch_pkg::op_class_e         fetch_op,
  output logic                         fetch_redirected
);

  logic                       redirect_valid;
  logic [fetch_pkg::xlen-1:0] redirect_pc;
  logic                       take;

  fetch_result_if res_if ();

  redirect_unit u_redirect_unit (
    .clk            (clk),
    .rst            (rst),
    .bj_ena         (bj_ena),
    .bj_pc          (bj_pc),
    .excp_ena       (excp_ena),
    .excp_pc        (excp_pc),
    .take           (take),
    .redirect_valid (redirect_valid),
    .redirect_pc    (redirect_pc)
  );

  if_stage u_if_stage (
    .clk            (clk),
    .rst            (rst),
    .refresh        (refresh),
    .redirect_valid (redirect_valid),
    .redirect_pc    (redirect_pc),
    .take           (take),
    .bus_valid      (bus_valid),
    .bus_ready      (bus_ready),
    .bus_addr       (bus_addr),
    .bus_rdata      (bus_rdata),
    .res            (res_if.producer)
  );

  fetch_packer u_fetch_packer (
    .res              (res_if.consumer),
    .fetch_valid      (fetch_valid),
    .fetch_pc         (fetch_pc),
    .fetch_inst       (fetch_inst),
    .fetch_op         (fetch_op),
    .fetch_redirected (fetch_redirected)
  );

endmodule

// ==== logic/if_stage.sv ====
/* instruction fetch stage
   bus master FSM holding the fetch address and the last fetched pc and instruction */
`timescale 1ns/1ps

module if_stage (
  input  logic                       clk,
  input  logic                       rst,
  input  logic                       refresh,         // start the next fetch
  input  logic                       redirect_valid,
  input  logic [fetch_pkg::xlen-1:0] redirect_pc,
  output logic                       take,            // redirect consumed
  output logic                       bus_valid,
  input  logic                       bus_ready,
  output logic [fetch_pkg::xlen-1:0] bus_addr,
  input  logic [fetch_pkg::xlen-1:0] bus_rdata,
  fetch_result_if.producer           res
);

  fetch_pkg::fetch_state_e state;
  fetch_pkg::fetch_state_e state_nxt;

  logic handshake;

  logic [fetch_pkg::xlen-1:0]   pc_q;
  logic [fetch_pkg::inst_w-1:0] inst_q;
  logic                         redirected_q;

  assign bus_valid = (state == fetch_pkg::addr);
  assign handshake = bus_valid & bus_ready;
  assign take      = handshake;  // next address is loaded in this cycle

  always_ff @(posedge clk) begin
    if (rst) begin
      state <= fetch_pkg::idle;
    end else begin
      state <= state_nxt;
    end
  end

  always_comb begin
    state_nxt = state;
    case (state)
      fetch_pkg::idle: begin
        if (refresh) state_nxt = fetch_pkg::addr;
      end
      fetch_pkg::addr: begin
        if (handshake) state_nxt = fetch_pkg::retn;  // single outstanding request
      end
      fetch_pkg::retn: begin
        if (refresh) state_nxt = fetch_pkg::addr;
      end
      default: state_nxt = fetch_pkg::idle;
    endcase
  end

  // fetch address, starts at the reset pc
  always_ff @(posedge clk) begin
    if (rst) begin
      bus_addr <= fetch_pkg::pc_start;
    end else if (handshake) begin
      if (redirect_valid) begin
        bus_addr <= redirect_pc;
      end else begin
        bus_addr <= bus_addr + fetch_pkg::pc_step;
      end
    end
  end

  // captured item
  always_ff @(posedge clk) begin
    if (handshake) begin
      pc_q         <= bus_addr;
      inst_q       <= bus_rdata[fetch_pkg::inst_w-1:0];  // upper half unused
      redirected_q <= redirect_valid;
    end
  end

  assign res.done       = (state == fetch_pkg::retn) && !refresh;
  assign res.pc         = pc_q;
  assign res.inst       = inst_q;
  assign res.redirected = redirected_q;

  // request held until the slave accepts it
  a_bus_hold: assert property (
    @(posedge clk) disable iff (rst)
    bus_valid && !bus_ready |=> bus_valid && $stable(bus_addr)
  ) else $error("bus request dropped or changed before handshake");

endmodule

// ==== logic/redirect_unit.sv ====
/* redirect unit
   holds one branch or exception target until the fetch FSM takes it, exceptions first */
`timescale 1ns/1ps

module redirect_unit (
  input  logic                       clk,
  input  logic                       rst,
  input  logic                       bj_ena,
  input  logic [fetch_pkg::xlen-1:0] bj_pc,
  input  logic                       excp_ena,
  input  logic [fetch_pkg::xlen-1:0] excp_pc,
  input  logic                       take,
  output logic                       redirect_valid,
  output logic [fetch_pkg::xlen-1:0] redirect_pc
);

  logic                       pend_valid;
  logic                       pend_excp;  // pending target is an exception
  logic [fetch_pkg::xlen-1:0] pend_pc;

  logic excp_held;

  assign excp_held = pend_valid & pend_excp;

  // bypass so a request is visible the cycle it arrives
  assign redirect_valid = pend_valid | bj_ena | excp_ena;

  always_comb begin
    if (excp_ena) begin
      redirect_pc = excp_pc;
    end else if (bj_ena && !excp_held) begin
      redirect_pc = bj_pc;
    end else begin
      redirect_pc = pend_pc;
    end
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      pend_valid <= 1'b0;
      pend_excp  <= 1'b0;
    end else if (take) begin
      pend_valid <= 1'b0;  // anything arriving now went out through the bypass
      pend_excp  <= 1'b0;
    end else if (excp_ena) begin
      pend_valid <= 1'b1;
      pend_excp  <= 1'b1;
    end else if (bj_ena && !excp_held) begin
      pend_valid <= 1'b1;
      pend_excp  <= 1'b0;
    end
  end

  always_ff @(posedge clk) begin
    if (!take) begin
      if (excp_ena) begin
        pend_pc <= excp_pc;
      end else if (bj_ena && !excp_held) begin
        pend_pc <= bj_pc;
      end
    end
  end

  // a taken redirect is gone next cycle unless a fresh one shows up
  a_take_clears: assert property (
    @(posedge clk) disable iff (rst)
    take |=> !redirect_valid || bj_ena || excp_ena
  ) else $error("redirect still pending after take");

endmodule

// ==== run_sim.sh ====
#!/bin/sh
# build and run the fetch testbench with Verilator
set -e
cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --timing --assert --timescale 1ns/1ps \
  -f flist.f --top-module fetch_tb -o fetch_sim

# the log decides the result
./obj_dir/fetch_sim > sim.log 2>&1 || true
cat sim.log

if grep -qx "Finished with no errors" sim.log; then
  echo "simulation passed"
else
  echo "simulation failed"
  exit 1
fi

// ==== verification/fetch_mem_model.sv ====
/* instruction memory model
   bus slave with a random ready delay and read data built from the address */
`timescale 1ns/1ps

module fetch_mem_model (
  input  logic                       clk,
  input  logic                       rst,
  input  logic                       bus_valid,
  output logic                       bus_ready,
  input  logic [fetch_pkg::xlen-1:0] bus_addr,
  output logic [fetch_pkg::xlen-1:0] bus_rdata
);

  integer      seed = 60789;
  integer      rnd;
  logic [1:0]  wait_cnt;  // cycles left before ready
  logic [31:0] enc;
  logic [31:0] word;

  // a fresh delay of 0 to 3 cycles for every request
  always @(posedge clk) begin
    if (rst || (bus_valid && bus_ready)) begin
      rnd = $random(seed);
      wait_cnt <= rnd[1:0];
    end else if (bus_valid && wait_cnt != 2'd0) begin
      wait_cnt <= wait_cnt - 2'd1;
    end
  end

  assign bus_ready = bus_valid && (wait_cnt == 2'd0);

  always_comb begin
    case (bus_addr[4:2])
      3'd0:    enc = 32'h0000_0093;  // addi x1, x0, 0
      3'd1:    enc = 32'h0000_b103;  // ld x2, 0(x1)
      3'd2:    enc = 32'h0020_b023;  // sd x2, 0(x1)
      3'd3:    enc = 32'h0020_8063;  // beq x1, x2
      3'd4:    enc = 32'h0000_00ef;  // jal x1
      3'd5:    enc = 32'h0000_8067;  // jalr x0, 0(x1)
      3'd6:    enc = 32'h0000_0073;  // ecall
      default: enc = 32'h0000_0001;  // compressed form, illegal here
    endcase
  end

  // addr[11:5] folded into the top immediate bits
  assign word      = enc ^ {bus_addr[11:5], 25'd0};
  assign bus_rdata = {~bus_addr[31:0], word};  // upper half is not an instruction

endmodule

// ==== verification/fetch_tb.sv ====
/* fetch subsystem testbench
   drives refresh and redirects against a stalling bus model and checks every fetched item */
`timescale 1ns/1ps

module fetch_tb;

  localparam int n_fetch   = 29;  // fetches issued by the tests below
  localparam int wd_cycles = n_fetch * 20 + 200;

  logic                         clk;
  logic                         rst;
  logic                         refresh;
  logic                         bj_ena;
  logic [fetch_pkg::xlen-1:0]   bj_pc;
  logic                         excp_ena;
  logic [fetch_pkg::xlen-1:0]   excp_pc;
  logic                         bus_valid;
  logic                         bus_ready;
  logic [fetch_pkg::xlen-1:0]   bus_addr;
  logic [fetch_pkg::xlen-1:0]   bus_rdata;
  logic                         fetch_valid;
  logic [fetch_pkg::xlen-1:0]   fetch_pc;
  logic [fetch_pkg::inst_w-1:0] fetch_inst;
  fetch_pkg::op_class_e         fetch_op;
  logic                         fetch_redirected;

  // reference pc tracker
  logic [fetch_pkg::xlen-1:0] ref_addr;
  logic [fetch_pkg::xlen-1:0] pend_pc;
  logic                       pend_valid;
  logic                       pend_excp;
  logic [fetch_pkg::xlen-1:0] exp_pc_q [$];
  logic                       exp_redir_q [$];

  logic [fetch_pkg::xlen-1:0] exp_pc;
  logic [34:0]                exp_item;  // {class, instruction}
  logic                       prev_valid;
  logic [fetch_pkg::xlen-1:0] seq_pc;
  logic [fetch_pkg::xlen-1:0] tgt;
  int                         stall_hits;

  fetch_top u_fetch_top (.*);

  fetch_mem_model u_fetch_mem_model (.*);

  initial clk = 1'b0;
  always #2 clk = ~clk;

  // expected word and class per table slot
  function automatic logic [34:0] ref_item(input logic [fetch_pkg::xlen-1:0] a);
    logic [34:0] e;
    case (a[4:2])
      3'd0:    e = {fetch_pkg::op_alu, 32'h0000_0093};
      3'd1:    e = {fetch_pkg::op_load, 32'h0000_b103};
      3'd2:    e = {fetch_pkg::op_store, 32'h0020_b023};
      3'd3:    e = {fetch_pkg::op_branch, 32'h0020_8063};
      3'd4:    e = {fetch_pkg::op_jal, 32'h0000_00ef};
      3'd5:    e = {fetch_pkg::op_jalr, 32'h0000_8067};
      3'd6:    e = {fetch_pkg::op_system, 32'h0000_0073};
      default: e = {fetch_pkg::op_illegal, 32'h0000_0001};  // low bits not 11
    endcase
    return e ^ {3'b000, a[11:5], 25'd0};
  endfunction

  task automatic stop_run();
    $display("Finished with errors");
    $fatal(1, "stopped at the first error");
  endtask

  task automatic check_pc(input logic [fetch_pkg::xlen-1:0] got,
                          input logic [fetch_pkg::xlen-1:0] exp, input string what);
    if (got !== exp) begin
      $display("CHECK FAILED at time %0t: %s got %h expected %h", $time, what, got, exp);
      stop_run();
    end
  endtask

  task automatic check_inst(input logic [fetch_pkg::inst_w-1:0] got,
                            input logic [fetch_pkg::inst_w-1:0] exp, input string what);
    if (got !== exp) begin
      $display("CHECK FAILED at time %0t: %s got %h expected %h", $time, what, got, exp);
      stop_run();
    end
  endtask

  task automatic check_op(input fetch_pkg::op_class_e got, input fetch_pkg::op_class_e exp,
                          input string what);
    if (got !== exp) begin
      $display("CHECK FAILED at time %0t: %s got %s expected %s", $time, what,
               got.name(), exp.name());
      stop_run();
    end
  endtask

  task automatic check_flag(input logic got, input logic exp, input string what);
    if (got !== exp) begin
      $display("CHECK FAILED at time %0t: %s got %b expected %b", $time, what, got, exp);
      stop_run();
    end
  endtask

  // follows the bus handshakes with exceptions beating branches
  always @(negedge clk) begin
    if (rst) begin
      ref_addr   = fetch_pkg::pc_start;
      pend_valid = 1'b0;
      pend_excp  = 1'b0;
    end else if (bus_valid && bus_ready) begin
      check_pc(bus_addr, ref_addr, "bus address");
      exp_pc_q.push_back(ref_addr);
      exp_redir_q.push_back(excp_ena || bj_ena || pend_valid);
      ref_addr   = excp_ena ? excp_pc : (bj_ena && !pend_excp) ? bj_pc
                 : pend_valid ? pend_pc : ref_addr + 64'd4;
      pend_valid = 1'b0;
      pend_excp  = 1'b0;
    end else if (excp_ena || (bj_ena && !pend_excp)) begin
      pend_valid = 1'b1;
      pend_excp  = excp_ena;
      pend_pc    = excp_ena ? excp_pc : bj_pc;
    end
  end

  // one compare per new item on the output
  always @(negedge clk) begin
    if (rst) begin
      prev_valid = 1'b0;
    end else begin
      if (fetch_valid && !prev_valid) begin
        if (exp_pc_q.size() == 0) begin
          $display("an item was presented at time %0t with no bus read behind it", $time);
          stop_run();
        end else begin
          exp_pc   = exp_pc_q.pop_front();
          exp_item = ref_item(exp_pc);
          check_pc(fetch_pc, exp_pc, "fetched pc");
          check_inst(fetch_inst, exp_item[31:0], "fetched instruction");
          check_op(fetch_op, fetch_pkg::op_class_e'(exp_item[34:32]), "opcode class");
          check_flag(fetch_redirected, exp_redir_q.pop_front(), "redirected flag");
        end
      end
      prev_valid = fetch_valid;
    end
  end

  initial begin
    repeat (wd_cycles) @(posedge clk);
    $display("timeout after %0d cycles, the fetch sequence did not complete", wd_cycles);
    $display("Finished with errors");
    $fatal(1, "watchdog expired");
  end

  // requests held for one cycle and then dropped
  task automatic pulse_inputs(input logic rf, input logic bj,
                              input logic [fetch_pkg::xlen-1:0] bjt, input logic ex,
                              input logic [fetch_pkg::xlen-1:0] ext);
    @(posedge clk);
    #1;
    refresh  = rf;
    bj_ena   = bj;
    bj_pc    = bjt;
    excp_ena = ex;
    excp_pc  = ext;
    @(posedge clk);
    #1;
    refresh  = 1'b0;
    bj_ena   = 1'b0;
    excp_ena = 1'b0;
  endtask

  // optionally one branch while the bus holds off ready
  task automatic wait_fetch(input logic stall_redirect, input logic [fetch_pkg::xlen-1:0] t);
    logic armed;
    armed = stall_redirect;
    while (!fetch_valid) begin
      if (armed && bus_valid && !bus_ready) begin
        armed  = 1'b0;
        stall_hits++;
        bj_ena = 1'b1;  // lands in this stalled cycle
        bj_pc  = t;
      end
      @(posedge clk);
      #1;
      bj_ena = 1'b0;
    end
  endtask

  task automatic fetch_item(input logic bj, input logic [fetch_pkg::xlen-1:0] bjt,
                            input logic ex, input logic [fetch_pkg::xlen-1:0] ext);
    pulse_inputs(1'b1, bj, bjt, ex, ext);
    wait_fetch(1'b0, '0);
  endtask

  // current item flagged and the next one landing on the target
  task automatic expect_redirect(input logic [fetch_pkg::xlen-1:0] t, input string what);
    check_flag(fetch_redirected, 1'b1, what);
    fetch_item(1'b0, '0, 1'b0, '0);
    check_pc(fetch_pc, t, what);
  endtask

  initial begin
    rst        = 1'b1;
    refresh    = 1'b0;
    bj_ena     = 1'b0;
    bj_pc      = '0;
    excp_ena   = 1'b0;
    excp_pc    = '0;
    stall_hits = 0;
    repeat (3) @(posedge clk);
    #1;
    rst = 1'b0;
    repeat (2) begin
      @(negedge clk);
      check_flag(fetch_valid, 1'b0, "fetch_valid before first refresh");
      check_flag(bus_valid, 1'b0, "bus_valid before first refresh");
    end

    // reset pc first and then every table slot in order
    seq_pc = fetch_pkg::pc_start;
    for (int i = 0; i < 9; i++) begin
      fetch_item(1'b0, '0, 1'b0, '0);
      check_pc(fetch_pc, seq_pc, "sequential fetch");
      seq_pc = seq_pc + 64'd4;
    end

    fetch_item(1'b1, 64'h0000_0000_8000_0400, 1'b0, '0);
    expect_redirect(64'h0000_0000_8000_0400, "branch redirect");

    // both in one cycle
    fetch_item(1'b1, 64'h0000_0000_8000_0800, 1'b1, 64'h0000_0000_8000_0c14);
    expect_redirect(64'h0000_0000_8000_0c14, "exception with branch");

    // exception over a pending branch
    pulse_inputs(1'b0, 1'b1, 64'h0000_0000_8000_1008, 1'b0, '0);
    pulse_inputs(1'b0, 1'b0, '0, 1'b1, 64'h0000_0000_8000_1104);
    fetch_item(1'b0, '0, 1'b0, '0);
    expect_redirect(64'h0000_0000_8000_1104, "exception after branch");

    // branch must not replace a pending exception
    pulse_inputs(1'b0, 1'b0, '0, 1'b1, 64'h0000_0000_8000_1210);
    pulse_inputs(1'b0, 1'b1, 64'h0000_0000_8000_1300, 1'b0, '0);
    fetch_item(1'b0, '0, 1'b0, '0);
    expect_redirect(64'h0000_0000_8000_1210, "branch after exception");

    tgt = 64'h0000_0000_8000_2000;
    for (int i = 0; i < 12; i++) begin
      pulse_inputs(1'b1, 1'b0, '0, 1'b0, '0);
      wait_fetch(1'b1, tgt);
      tgt = tgt + 64'h44;
    end
    if (stall_hits == 0) begin
      $display("no bus stall came up, so no redirect was given during a stall");
      stop_run();
    end

    repeat (2) @(negedge clk);
    if (exp_pc_q.size() == 0) begin
      $display("Finished with no errors");
      $finish;
    end else begin
      $display("%0d bus reads never showed up at the fetch output", exp_pc_q.size());
      $display("Finished with errors");
      $fatal(1, "fetch output incomplete");
    end
  end

endmodule
